// ==== controlUnit.f ====
hdl/controlPkg.sv
hdl/controlIf.sv
hdl/instrDecoder.sv
hdl/sequencer.sv
hdl/aluRegControl.sv
hdl/memPcControl.sv
hdl/controlUnit.sv
tests/controlUnitTb.sv

// ==== hdl/aluRegControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluRegControl
(
	input logic clk,
	input logic reset,
	input controlPkg::stateT state,
	input controlPkg::instrClassT instrClass,
	input controlPkg::aluOpT aluOp,
	input logic menor,
	aluRegIf.source ctrl
);

	always_comb
	begin
		ctrl.aluSrcA = 1'b0;
		ctrl.aluSrcB = controlPkg::srcRegB;
		ctrl.aluControl = controlPkg::aluPass;
		ctrl.regAluControl = 1'b0;
		ctrl.writeA = 1'b0;
		ctrl.writeB = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.regDst = controlPkg::dstRt;
		ctrl.memToReg = controlPkg::wbAluOut;
		case (state)
			controlPkg::Fetch, controlPkg::FetchWait, controlPkg::IrLoad:
			begin
				ctrl.aluSrcB = controlPkg::srcFour; // pc + 4
				ctrl.aluControl = controlPkg::aluAdd;
			end
			controlPkg::Decode:
			begin
				ctrl.aluSrcB = controlPkg::srcBranchOffset; // branch target ahead of time
				ctrl.aluControl = controlPkg::aluAdd;
				ctrl.regAluControl = 1'b1;
				ctrl.writeA = 1'b1;
				ctrl.writeB = 1'b1;
			end
			controlPkg::AluExec, controlPkg::AluImmExec:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = (state == controlPkg::AluImmExec) ? controlPkg::srcSignImm :
					controlPkg::srcRegB;
				ctrl.aluControl = aluOp;
				ctrl.regAluControl = 1'b1;
			end
			controlPkg::AluWrite:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = (instrClass == controlPkg::aluReg) ? controlPkg::dstRd :
					controlPkg::dstRt;
			end
			controlPkg::SltExec, controlPkg::SltWrite:
			begin
				ctrl.aluSrcA = 1'b1; // compare kept up so menor stays valid
				ctrl.aluSrcB = (instrClass == controlPkg::sltImm) ? controlPkg::srcSignImm :
					controlPkg::srcRegB;
				ctrl.aluControl = controlPkg::aluCompare;
				if (state == controlPkg::SltWrite)
				begin
					ctrl.regWrite = 1'b1;
					ctrl.regDst = controlPkg::dstRd;
					ctrl.memToReg = menor ? controlPkg::wbOne : controlPkg::wbZero;
				end
			end
			controlPkg::Branch:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluControl = controlPkg::aluSub; // zero flag decides
			end
			controlPkg::JalLink:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = controlPkg::dstRa31;
				ctrl.memToReg = controlPkg::wbPcLink;
			end
			controlPkg::LoadUpper:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = controlPkg::wbUpperImm;
			end
			controlPkg::MemAddr:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = controlPkg::srcSignImm;
				ctrl.aluControl = controlPkg::aluAdd;
				ctrl.regAluControl = 1'b1;
			end
			controlPkg::LoadWrite:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = controlPkg::wbMemData;
			end
			default: ctrl.regWrite = 1'b0;
		endcase
	end

	singleWrite: assert property (@(posedge clk) disable iff (reset)
		ctrl.regWrite |=> (!ctrl.regWrite until (state == controlPkg::Fetch)))
		else $error("more than one register write in one instruction");

endmodule

`default_nettype wire

// ==== hdl/controlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface aluRegIf;
	logic aluSrcA; // 0 selects PC, 1 selects A
	controlPkg::aluSrcBT aluSrcB;
	controlPkg::aluOpT aluControl;
	logic regAluControl; // aluOut register load
	logic writeA;
	logic writeB;
	logic regWrite;
	controlPkg::regDstT regDst;
	controlPkg::memToRegT memToReg;

	modport source (output aluSrcA, aluSrcB, aluControl, regAluControl, writeA, writeB,
		regWrite, regDst, memToReg);
	modport sink (input aluSrcA, aluSrcB, aluControl, regAluControl, writeA, writeB,
		regWrite, regDst, memToReg);
endinterface

interface memPcIf;
	logic memWriteOrRead;
	logic mdrControl;
	logic [1:0] IorD; // 00 pc, 01 aluOut
	logic irWrite;
	logic pcControl;
	logic pcCond;
	controlPkg::pcSrcT origPC;
	logic bneORbeq;

	modport source (output memWriteOrRead, mdrControl, IorD, irWrite, pcControl, pcCond,
		origPC, bneORbeq);
	modport sink (input memWriteOrRead, mdrControl, IorD, irWrite, pcControl, pcCond,
		origPC, bneORbeq);
endinterface

`default_nettype wire

// ==== hdl/controlPkg.sv ====
`default_nettype none

package controlPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	typedef enum logic [opcodeWidth-1:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opAddiu = 6'h09,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opXori  = 6'h0e,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	typedef enum logic [functWidth-1:0] {
		fnNop   = 6'h00,
		fnJr    = 6'h08,
		fnBreak = 6'h0d,
		fnAdd   = 6'h20,
		fnSub   = 6'h22,
		fnAnd   = 6'h24,
		fnXor   = 6'h26,
		fnSlt   = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		aluReg, aluImm, sltReg, sltImm, branchEq, branchNe, jump,
		jumpReg, jumpLink, loadUpper, loadWord, storeWord, halt, noOp
	} instrClassT;

	typedef enum logic [4:0] {
		Reset, Fetch, FetchWait, IrLoad, Decode, AluExec, AluImmExec, AluWrite,
		SltExec, SltWrite, Branch, Jump, JumpReg, JalLink, JalJump, LoadUpper,
		MemAddr, LoadWait, MdrLoad, LoadWrite, StoreWrite, NoOp, Halt
	} stateT;

	typedef enum logic [2:0] {
		aluPass    = 3'b000,
		aluAdd     = 3'b001,
		aluSub     = 3'b010,
		aluAnd     = 3'b011,
		aluXor     = 3'b110,
		aluCompare = 3'b111
	} aluOpT;

	typedef enum logic [1:0] {srcRegB, srcFour, srcSignImm, srcBranchOffset} aluSrcBT;

	typedef enum logic [1:0] {pcAluOut, pcBranchTarget, pcJumpTarget, pcRegA} pcSrcT;

	typedef enum logic [1:0] {dstRt, dstRd, dstRa31} regDstT;

	typedef enum logic [2:0] {
		wbAluOut   = 3'd0,
		wbMemData  = 3'd1,
		wbUpperImm = 3'd2,
		wbZero     = 3'd3,
		wbOne      = 3'd4,
		wbPcLink   = 3'd6 // same code as the datapath mux input
	} memToRegT;

endpackage

`default_nettype wire

// ==== hdl/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit
#(
	parameter int memWaitCycles = 1 // 1 to 4
)
(
	input logic clk,
	input logic reset,
	input logic [controlPkg::opcodeWidth-1:0] opcode,
	input logic [controlPkg::functWidth-1:0] funct,
	input logic menor,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic [1:0] IorD,
	output logic pcControl,
	output logic pcCond,
	output controlPkg::pcSrcT origPC,
	output logic bneORbeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output controlPkg::aluSrcBT aluSrcB,
	output controlPkg::aluOpT aluControl,
	output logic regAluControl,
	output controlPkg::regDstT regDst,
	output controlPkg::memToRegT memToReg
);

	controlPkg::instrClassT instrClass;
	controlPkg::aluOpT aluOp;
	controlPkg::stateT state;

	aluRegIf aluRegSig();
	memPcIf memPcSig();

	instrDecoder i_instrDecoder (.opcode(opcode), .funct(funct), .instrClass(instrClass),
		.aluOp(aluOp));

	sequencer #(.memWaitCycles(memWaitCycles)) i_sequencer (.clk(clk), .reset(reset),
		.instrClass(instrClass), .state(state));

	aluRegControl i_aluRegControl (.clk(clk), .reset(reset), .state(state),
		.instrClass(instrClass), .aluOp(aluOp), .menor(menor), .ctrl(aluRegSig));

	memPcControl i_memPcControl (.clk(clk), .reset(reset), .state(state),
		.instrClass(instrClass), .ctrl(memPcSig));

	assign aluSrcA = aluRegSig.aluSrcA;
	assign aluSrcB = aluRegSig.aluSrcB;
	assign aluControl = aluRegSig.aluControl;
	assign regAluControl = aluRegSig.regAluControl;
	assign writeA = aluRegSig.writeA;
	assign writeB = aluRegSig.writeB;
	assign regWrite = aluRegSig.regWrite;
	assign regDst = aluRegSig.regDst;
	assign memToReg = aluRegSig.memToReg;

	assign memWriteOrRead = memPcSig.memWriteOrRead;
	assign mdrControl = memPcSig.mdrControl;
	assign IorD = memPcSig.IorD;
	assign irWrite = memPcSig.irWrite;
	assign pcControl = memPcSig.pcControl;
	assign pcCond = memPcSig.pcCond;
	assign origPC = memPcSig.origPC;
	assign bneORbeq = memPcSig.bneORbeq;

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecoder
(
	input logic [controlPkg::opcodeWidth-1:0] opcode,
	input logic [controlPkg::functWidth-1:0] funct,
	output controlPkg::instrClassT instrClass,
	output controlPkg::aluOpT aluOp
);

	always_comb
	begin
		instrClass = controlPkg::noOp; // unknown codes run as nop
		aluOp = controlPkg::aluPass;
		case (opcode)
			controlPkg::opRType:
			begin
				case (funct)
					controlPkg::fnAdd:
					begin
						instrClass = controlPkg::aluReg;
						aluOp = controlPkg::aluAdd;
					end
					controlPkg::fnSub:
					begin
						instrClass = controlPkg::aluReg;
						aluOp = controlPkg::aluSub;
					end
					controlPkg::fnAnd:
					begin
						instrClass = controlPkg::aluReg;
						aluOp = controlPkg::aluAnd;
					end
					controlPkg::fnXor:
					begin
						instrClass = controlPkg::aluReg;
						aluOp = controlPkg::aluXor;
					end
					controlPkg::fnSlt: instrClass = controlPkg::sltReg;
					controlPkg::fnJr: instrClass = controlPkg::jumpReg;
					controlPkg::fnBreak: instrClass = controlPkg::halt;
					default: instrClass = controlPkg::noOp;
				endcase
			end
			controlPkg::opBeq: instrClass = controlPkg::branchEq;
			controlPkg::opBne: instrClass = controlPkg::branchNe;
			controlPkg::opLw: instrClass = controlPkg::loadWord;
			controlPkg::opSw: instrClass = controlPkg::storeWord;
			controlPkg::opLui: instrClass = controlPkg::loadUpper;
			controlPkg::opJ: instrClass = controlPkg::jump;
			controlPkg::opJal: instrClass = controlPkg::jumpLink;
			controlPkg::opSlti: instrClass = controlPkg::sltImm;
			controlPkg::opAddi, controlPkg::opAddiu:
			begin
				instrClass = controlPkg::aluImm; // no overflow trap
				aluOp = controlPkg::aluAdd;
			end
			controlPkg::opAndi:
			begin
				instrClass = controlPkg::aluImm;
				aluOp = controlPkg::aluAnd;
			end
			controlPkg::opXori:
			begin
				instrClass = controlPkg::aluImm;
				aluOp = controlPkg::aluXor;
			end
			default: instrClass = controlPkg::noOp;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/memPcControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module memPcControl
(
	input logic clk,
	input logic reset,
	input controlPkg::stateT state,
	input controlPkg::instrClassT instrClass,
	memPcIf.source ctrl
);

	always_comb
	begin
		ctrl.memWriteOrRead = 1'b0;
		ctrl.mdrControl = 1'b0;
		ctrl.IorD = 2'b00;
		ctrl.irWrite = 1'b0;
		ctrl.pcControl = 1'b0;
		ctrl.pcCond = 1'b0;
		ctrl.origPC = controlPkg::pcAluOut;
		ctrl.bneORbeq = 1'b0;
		case (state)
			controlPkg::Fetch, controlPkg::FetchWait: ctrl.irWrite = 1'b1;
			controlPkg::IrLoad:
			begin
				ctrl.irWrite = 1'b1;
				ctrl.pcControl = 1'b1; // pc + 4 from aluOut
			end
			controlPkg::Branch:
			begin
				ctrl.pcCond = 1'b1;
				ctrl.origPC = controlPkg::pcBranchTarget;
				ctrl.bneORbeq = instrClass == controlPkg::branchEq;
			end
			controlPkg::Jump, controlPkg::JalJump:
			begin
				ctrl.pcControl = 1'b1;
				ctrl.origPC = controlPkg::pcJumpTarget;
			end
			controlPkg::JumpReg:
			begin
				ctrl.pcControl = 1'b1;
				ctrl.origPC = controlPkg::pcRegA;
			end
			controlPkg::LoadWait: ctrl.IorD = 2'b01; // data address from aluOut
			controlPkg::MdrLoad:
			begin
				ctrl.IorD = 2'b01;
				ctrl.mdrControl = 1'b1;
			end
			controlPkg::StoreWrite:
			begin
				ctrl.IorD = 2'b01;
				ctrl.memWriteOrRead = 1'b1;
			end
			default: ctrl.irWrite = 1'b0;
		endcase
	end

	noWriteDuringFetch: assert property (@(posedge clk) disable iff (reset)
		ctrl.memWriteOrRead |-> !ctrl.irWrite)
		else $error("memory write while loading the IR");

	condExclusive: assert property (@(posedge clk) disable iff (reset)
		ctrl.pcCond |-> !ctrl.pcControl)
		else $error("pcCond and pcControl high together");

endmodule

`default_nettype wire

// ==== hdl/sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sequencer
#(
	parameter int memWaitCycles = 1
)
(
	input logic clk,
	input logic reset,
	input controlPkg::instrClassT instrClass,
	output controlPkg::stateT state
);

	localparam int cntWidth = $clog2(memWaitCycles + 1);

	controlPkg::stateT nextState;
	logic [cntWidth-1:0] waitCnt;
	logic [cntWidth-1:0] waitLimit;
	logic waitState;
	logic waitDone;

	// store holds its write one cycle longer than a read wait
	assign waitState = state inside {controlPkg::FetchWait, controlPkg::LoadWait,
		controlPkg::StoreWrite};
	assign waitLimit = (state == controlPkg::StoreWrite) ? cntWidth'(memWaitCycles) :
		cntWidth'(memWaitCycles - 1);
	assign waitDone = waitCnt == waitLimit;

	always_comb
	begin
		nextState = state;
		case (state)
			controlPkg::Reset: nextState = controlPkg::Fetch;
			controlPkg::Fetch: nextState = controlPkg::FetchWait;
			controlPkg::FetchWait: if (waitDone) nextState = controlPkg::IrLoad;
			controlPkg::IrLoad: nextState = controlPkg::Decode;
			controlPkg::Decode:
			begin
				case (instrClass)
					controlPkg::aluReg: nextState = controlPkg::AluExec;
					controlPkg::aluImm: nextState = controlPkg::AluImmExec;
					controlPkg::sltReg, controlPkg::sltImm: nextState = controlPkg::SltExec;
					controlPkg::branchEq, controlPkg::branchNe: nextState = controlPkg::Branch;
					controlPkg::jump: nextState = controlPkg::Jump;
					controlPkg::jumpReg: nextState = controlPkg::JumpReg;
					controlPkg::jumpLink: nextState = controlPkg::JalLink;
					controlPkg::loadUpper: nextState = controlPkg::LoadUpper;
					controlPkg::loadWord, controlPkg::storeWord: nextState = controlPkg::MemAddr;
					controlPkg::halt: nextState = controlPkg::Halt;
					default: nextState = controlPkg::NoOp;
				endcase
			end
			controlPkg::AluExec, controlPkg::AluImmExec: nextState = controlPkg::AluWrite;
			controlPkg::SltExec: nextState = controlPkg::SltWrite;
			controlPkg::JalLink: nextState = controlPkg::JalJump;
			controlPkg::MemAddr: // IR still holds the instruction here
				nextState = (instrClass == controlPkg::storeWord) ? controlPkg::StoreWrite :
					controlPkg::LoadWait;
			controlPkg::LoadWait: if (waitDone) nextState = controlPkg::MdrLoad;
			controlPkg::MdrLoad: nextState = controlPkg::LoadWrite;
			controlPkg::StoreWrite: if (waitDone) nextState = controlPkg::Fetch;
			controlPkg::Halt: nextState = controlPkg::Halt;
			default: nextState = controlPkg::Fetch;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= controlPkg::Reset;
		else
			state <= nextState;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			waitCnt <= '0;
		else if (waitState && !waitDone)
			waitCnt <= waitCnt + 1'b1;
		else
			waitCnt <= '0;
	end

	haltHeld: assert property (@(posedge clk) disable iff (reset)
		state == controlPkg::Halt |=> state == controlPkg::Halt)
		else $error("sequencer left Halt without reset");

	waitBound: assert property (@(posedge clk) disable iff (reset)
		waitCnt <= memWaitCycles)
		else $error("wait counter above memWaitCycles");

endmodule

`default_nettype wire

// ==== tests/controlUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb;

	localparam int memWait = 2;
	localparam int numInstr = 300;
	localparam int timeoutCycles = numInstr * (2 * memWait + 6) + 50;

	logic clk;
	logic reset;
	logic [controlPkg::opcodeWidth-1:0] opcode;
	logic [controlPkg::functWidth-1:0] funct;
	logic menor;
	logic memWriteOrRead;
	logic mdrControl;
	logic [1:0] IorD;
	logic pcControl;
	logic pcCond;
	controlPkg::pcSrcT origPC;
	logic bneORbeq;
	logic irWrite;
	logic writeA;
	logic writeB;
	logic regWrite;
	logic aluSrcA;
	controlPkg::aluSrcBT aluSrcB;
	controlPkg::aluOpT aluControl;
	logic regAluControl;
	controlPkg::regDstT regDst;
	controlPkg::memToRegT memToReg;

	logic [15:0] lfsr = 16'd5079;
	int errorCount = 0;
	int instrCount = 0;
	int cycleCount = 0;
	int relCnt = 0; // cycles since reset release, saturates
	int kReg = 0;
	int kNow;
	int e;
	logic irWritePrev = 1'b0;
	logic fetchStart;
	logic started = 1'b0;
	logic active;
	logic haltIssued = 1'b0;
	controlPkg::instrClassT curClass = controlPkg::noOp;
	controlPkg::aluOpT curOp = controlPkg::aluPass;

	logic expIrWrite;
	logic expPcControl;
	logic expPcCond;
	controlPkg::pcSrcT expOrigPC;
	logic expRegWrite;
	controlPkg::regDstT expRegDst;
	controlPkg::memToRegT expMemToReg;
	logic expMdr;
	logic expMemWrite;
	logic aluUsed;
	logic expSrcA;
	controlPkg::aluSrcBT expSrcB;
	controlPkg::aluOpT expAluOp;
	logic expRegAlu;
	logic expWriteAB;

	controlUnit #(.memWaitCycles(memWait)) i_controlUnit (.clk(clk), .reset(reset),
		.opcode(opcode), .funct(funct), .menor(menor), .memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl), .IorD(IorD), .pcControl(pcControl), .pcCond(pcCond),
		.origPC(origPC), .bneORbeq(bneORbeq), .irWrite(irWrite), .writeA(writeA),
		.writeB(writeB), .regWrite(regWrite), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
		.aluControl(aluControl), .regAluControl(regAluControl), .regDst(regDst),
		.memToReg(memToReg));

	always #20 clk = ~clk;

	function automatic logic [15:0] galoisStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// cycles from one fetch start to the next
	function automatic int periodOf(input controlPkg::instrClassT cls);
		case (cls)
			controlPkg::aluReg, controlPkg::aluImm, controlPkg::sltReg, controlPkg::sltImm,
			controlPkg::jumpLink: return memWait + 5;
			controlPkg::loadWord: return 2 * memWait + 6;
			controlPkg::storeWord: return 2 * memWait + 5;
			default: return memWait + 4;
		endcase
	endfunction

	task automatic drawBits(input int n, output int value);
		int i;
		value = 0;
		for (i = 0; i < n; i++)
		begin
			value = (value << 1) | lfsr[0];
			lfsr = galoisStep(lfsr);
		end
	endtask

	task automatic countFailure(input string msg);
		errorCount++;
		$display("Mismatch at time %0t: %s", $time, msg);
	endtask

	task automatic issueNext;
		int pick;
		int variant;
		int bitVal;
		int junk;
		controlPkg::instrClassT cls;
		controlPkg::aluOpT opExp;
		logic [5:0] op;
		logic [5:0] fn;
		drawBits(4, pick);
		drawBits(2, variant);
		drawBits(1, bitVal);
		drawBits(6, junk);
		fn = 6'(junk); // funct is ignored outside R-type
		op = controlPkg::opRType;
		opExp = controlPkg::aluPass;
		case (pick % 13)
			0: cls = controlPkg::aluReg;
			1: cls = controlPkg::aluImm;
			2: cls = controlPkg::sltReg;
			3: cls = controlPkg::sltImm;
			4: cls = controlPkg::branchEq;
			5: cls = controlPkg::branchNe;
			6: cls = controlPkg::jump;
			7: cls = controlPkg::jumpReg;
			8: cls = controlPkg::jumpLink;
			9: cls = controlPkg::loadUpper;
			10: cls = controlPkg::loadWord;
			11: cls = controlPkg::storeWord;
			default: cls = controlPkg::noOp;
		endcase
		if (instrCount >= numInstr)
			cls = controlPkg::halt;
		case (cls)
			controlPkg::aluReg:
			begin
				case (variant)
					0:
					begin
						fn = controlPkg::fnAdd;
						opExp = controlPkg::aluAdd;
					end
					1:
					begin
						fn = controlPkg::fnSub;
						opExp = controlPkg::aluSub;
					end
					2:
					begin
						fn = controlPkg::fnAnd;
						opExp = controlPkg::aluAnd;
					end
					default:
					begin
						fn = controlPkg::fnXor;
						opExp = controlPkg::aluXor;
					end
				endcase
			end
			controlPkg::aluImm:
			begin
				case (variant)
					0:
					begin
						op = controlPkg::opAddi;
						opExp = controlPkg::aluAdd;
					end
					1:
					begin
						op = controlPkg::opAddiu;
						opExp = controlPkg::aluAdd;
					end
					2:
					begin
						op = controlPkg::opAndi;
						opExp = controlPkg::aluAnd;
					end
					default:
					begin
						op = controlPkg::opXori;
						opExp = controlPkg::aluXor;
					end
				endcase
			end
			controlPkg::sltReg: fn = controlPkg::fnSlt;
			controlPkg::sltImm: op = controlPkg::opSlti;
			controlPkg::branchEq: op = controlPkg::opBeq;
			controlPkg::branchNe: op = controlPkg::opBne;
			controlPkg::jump: op = controlPkg::opJ;
			controlPkg::jumpReg: fn = controlPkg::fnJr;
			controlPkg::jumpLink: op = controlPkg::opJal;
			controlPkg::loadUpper: op = controlPkg::opLui;
			controlPkg::loadWord: op = controlPkg::opLw;
			controlPkg::storeWord: op = controlPkg::opSw;
			controlPkg::halt: fn = controlPkg::fnBreak;
			default:
			begin
				if (variant[0])
					fn = controlPkg::fnNop;
				else
					op = 6'h3f; // undecoded opcode
			end
		endcase
		opcode <= op;
		funct <= fn;
		menor <= bitVal[0];
		curClass <= cls;
		curOp <= opExp;
		haltIssued <= cls == controlPkg::halt;
		if (cls != controlPkg::halt)
			instrCount <= instrCount + 1;
	endtask

	// new instruction on the edge that ends IrLoad
	always @(posedge clk)
	begin
		if (!reset && irWrite && pcControl && !haltIssued)
			issueNext();
	end

	assign fetchStart = irWrite && !irWritePrev;
	assign kNow = fetchStart ? 0 : kReg;
	assign active = started || fetchStart;

	always @(posedge clk)
	begin
		irWritePrev <= irWrite;
		if (reset)
		begin
			relCnt <= 0;
			kReg <= 0;
		end
		else
		begin
			if (relCnt < 2)
				relCnt <= relCnt + 1;
			kReg <= kNow + 1;
			if (fetchStart)
				started <= 1'b1;
		end
	end

	always_comb
	begin
		e = kNow - (memWait + 3); // execute cycle, negative in fetch
		expIrWrite = kNow <= memWait + 1;
		expPcControl = kNow == memWait + 1;
		expPcCond = 1'b0;
		expOrigPC = controlPkg::pcAluOut;
		expRegWrite = 1'b0;
		expRegDst = controlPkg::dstRt;
		expMemToReg = controlPkg::wbAluOut;
		expMdr = 1'b0;
		expMemWrite = 1'b0;
		aluUsed = kNow <= memWait + 2; // pc + 4, then the branch target in Decode
		expSrcA = 1'b0;
		expSrcB = (kNow == memWait + 2) ? controlPkg::srcBranchOffset : controlPkg::srcFour;
		expAluOp = controlPkg::aluAdd;
		expRegAlu = kNow == memWait + 2;
		expWriteAB = kNow == memWait + 2;
		case (curClass)
			controlPkg::aluReg, controlPkg::aluImm:
			begin
				expRegWrite = e == 1;
				if (curClass == controlPkg::aluReg)
					expRegDst = controlPkg::dstRd;
				if (e == 0)
				begin
					aluUsed = 1'b1;
					expSrcA = 1'b1;
					expSrcB = (curClass == controlPkg::aluReg) ? controlPkg::srcRegB :
						controlPkg::srcSignImm;
					expAluOp = curOp;
					expRegAlu = 1'b1;
				end
			end
			controlPkg::sltReg, controlPkg::sltImm:
			begin
				expRegWrite = e == 1;
				expRegDst = controlPkg::dstRd;
				expMemToReg = menor ? controlPkg::wbOne : controlPkg::wbZero;
				if (e == 0 || e == 1)
				begin
					aluUsed = 1'b1; // menor must hold through the write
					expSrcA = 1'b1;
					expSrcB = (curClass == controlPkg::sltImm) ? controlPkg::srcSignImm :
						controlPkg::srcRegB;
					expAluOp = controlPkg::aluCompare;
				end
			end
			controlPkg::branchEq, controlPkg::branchNe:
			begin
				if (e == 0)
				begin
					expPcCond = 1'b1;
					expOrigPC = controlPkg::pcBranchTarget;
					aluUsed = 1'b1;
					expSrcA = 1'b1;
					expSrcB = controlPkg::srcRegB;
					expAluOp = controlPkg::aluSub;
				end
			end
			controlPkg::jump, controlPkg::jumpReg:
			begin
				if (e == 0)
				begin
					expPcControl = 1'b1;
					expOrigPC = (curClass == controlPkg::jump) ? controlPkg::pcJumpTarget :
						controlPkg::pcRegA;
				end
			end
			controlPkg::jumpLink:
			begin
				expRegWrite = e == 0; // link first, then jump
				expRegDst = controlPkg::dstRa31;
				expMemToReg = controlPkg::wbPcLink;
				if (e == 1)
				begin
					expPcControl = 1'b1;
					expOrigPC = controlPkg::pcJumpTarget;
				end
			end
			controlPkg::loadUpper:
			begin
				expRegWrite = e == 0;
				expMemToReg = controlPkg::wbUpperImm;
			end
			controlPkg::loadWord, controlPkg::storeWord:
			begin
				if (e == 0)
				begin
					aluUsed = 1'b1; // base + offset
					expSrcA = 1'b1;
					expSrcB = controlPkg::srcSignImm;
					expAluOp = controlPkg::aluAdd;
					expRegAlu = 1'b1;
				end
				if (curClass == controlPkg::loadWord)
				begin
					expMdr = e == memWait + 1;
					expRegWrite = e == memWait + 2;
					expMemToReg = controlPkg::wbMemData;
				end
				else
					expMemWrite = e >= 1 && e <= memWait + 1;
			end
			default: expRegWrite = 1'b0;
		endcase
	end

	resetQuiet: assert property (@(posedge clk) relCnt == 0 |->
		!(regWrite || memWriteOrRead || irWrite || pcControl || pcCond || mdrControl ||
		writeA || writeB || regAluControl))
		else countFailure("enable high during reset or the cycle after it");
	firstFetch: assert property (@(posedge clk) disable iff (reset) relCnt == 1 |-> fetchStart)
		else countFailure("first irWrite not on the second cycle after reset");
	fetchPeriod: assert property (@(posedge clk) disable iff (reset)
		fetchStart && started |-> kReg == periodOf(curClass))
		else countFailure("fetch period does not match the instruction class");
	fetchAddr: assert property (@(posedge clk) disable iff (reset) fetchStart |-> IorD == 2'b00)
		else countFailure("IorD not selecting the PC in Fetch");
	irWriteCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> irWrite == expIrWrite)
		else countFailure("irWrite wrong");
	pcControlCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> pcControl == expPcControl)
		else countFailure("pcControl wrong");
	pcCondCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> pcCond == expPcCond)
		else countFailure("pcCond wrong");
	origPcCheck: assert property (@(posedge clk) disable iff (reset)
		active && (expPcControl || expPcCond) |-> origPC == expOrigPC)
		else countFailure("origPC wrong on a PC update");
	branchSense: assert property (@(posedge clk) disable iff (reset)
		active && expPcCond |-> bneORbeq == (curClass == controlPkg::branchEq))
		else countFailure("bneORbeq wrong for the branch");
	regWriteCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> regWrite == expRegWrite)
		else countFailure("regWrite wrong");
	writeTarget: assert property (@(posedge clk) disable iff (reset)
		active && expRegWrite |-> regDst == expRegDst && memToReg == expMemToReg)
		else countFailure("regDst or memToReg wrong on a register write");
	mdrCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> mdrControl == expMdr)
		else countFailure("mdrControl wrong");
	memWriteCheck: assert property (@(posedge clk) disable iff (reset)
		active |-> memWriteOrRead == expMemWrite)
		else countFailure("memWriteOrRead wrong");
	operandCheck: assert property (@(posedge clk) disable iff (reset)
		active && aluUsed |->
		aluSrcA == expSrcA && aluSrcB == expSrcB && aluControl == expAluOp)
		else countFailure("ALU operands or operation wrong");
	aluOutLoad: assert property (@(posedge clk) disable iff (reset)
		active |-> regAluControl == expRegAlu)
		else countFailure("regAluControl wrong");
	abLoad: assert property (@(posedge clk) disable iff (reset)
		active |-> writeA == expWriteAB && writeB == expWriteAB)
		else countFailure("writeA or writeB wrong");
	haltCheck: assert property (@(posedge clk) disable iff (reset) haltIssued |-> !fetchStart)
		else countFailure("irWrite rose again after break");

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: run did not reach the end within %0d cycles", timeoutCycles);
			$display("Errors before the timeout: %0d", errorCount);
			$display("TB FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		menor = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		wait (haltIssued);
		repeat (30) @(posedge clk); // halted, no fetch may follow
		$display("Summary: %0d instructions issued, %0d errors", instrCount, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
